//--- include/uvc_reader_config.svh
// UVC frame reader configuration
// frame geometry, line stride, beat FIFO depth and error pause timing

`ifndef UVC_READER_CONFIG_SVH
`define UVC_READER_CONFIG_SVH

// frame geometry, reduced for short simulations
`define UVC_LINE_PIXELS       16
`define UVC_FRAME_LINES       4
`define UVC_BEATS_PER_LINE    (`UVC_LINE_PIXELS / 4)  // four 16-bit pixels per beat

// 2048 byte line stride
`define UVC_LINE_STRIDE_BITS  11

// beat FIFO
`define UVC_FIFO_DEPTH        16

// recovery after a start-of-frame mismatch
`define UVC_ERROR_PAUSE       32
`define UVC_FLUSH_FIRST       1
`define UVC_FLUSH_LAST        16

`endif

//--- source/axi_read_pkg.sv
// AXI read channel types
// address, data and burst field encodings plus the line fetch FSM states

package axi_read_pkg;

    typedef logic [31:0] axi_addr_t;    // byte address
    typedef logic [63:0] axi_data_t;    // one read beat
    typedef logic [7:0]  axi_len_t;     // beats minus one

    // bytes per beat, log2 encoded
    typedef enum logic [2:0] {
        SIZE_1B, SIZE_2B, SIZE_4B, SIZE_8B,
        SIZE_16B, SIZE_32B, SIZE_64B, SIZE_128B
    } axi_size_e;

    typedef enum logic [1:0] {FIXED = 2'd0, INCR = 2'd1, WRAP = 2'd2} axi_burst_e;

    // line fetch sequencer
    typedef enum logic [2:0] {
        IDLE, LINE_ADDR, LINE_BURST, WAIT_ROOM, FRAME_REQ, FRAME_UPDATE, RESYNC
    } fetch_state_e;

endpackage

//--- source/video_stream_pkg.sv
// video stream types
// bytes toward the UVC consumer and the tagged beats held in the beat FIFO

`include "uvc_reader_config.svh"

package video_stream_pkg;

    typedef logic [7:0] vid_byte_t;

    // beat as stored in the FIFO
    typedef struct packed {
        logic        sof;   // first beat of a frame
        logic [63:0] data;
    } tagged_beat_t;

    // occupancy, 0 up to the full depth
    typedef logic [$clog2(`UVC_FIFO_DEPTH + 1) - 1:0] fifo_level_t;

endpackage

//--- source/fetch_ifs.sv
// beat push and beat pop interfaces
// push runs from the line fetch sequencer into the beat FIFO,
// pop runs from the beat FIFO to the byte serializer

`timescale 1ns/1ps

interface beat_push_if;

    logic                           push;   // one beat per strobe
    video_stream_pkg::tagged_beat_t beat;
    logic                           flush;  // empties the FIFO
    video_stream_pkg::fifo_level_t  level;

    modport sequencer (output push, output beat, output flush, input level);
    modport fifo (input push, input beat, input flush, output level);

endinterface

//----------------------------------------------------------------------

interface beat_pop_if;

    logic                    pop;        // removes the head at the edge
    axi_read_pkg::axi_data_t head_data;
    logic                    head_sof;   // frame start tag of the head
    logic                    not_empty;

    modport fifo (input pop, output head_data, output head_sof, output not_empty);
    modport serializer (output pop, input head_data, input head_sof, input not_empty);

endinterface

//--- source/line_fetch_sequencer.sv
// line fetch sequencer
// issues one AXI INCR burst per video line, counts lines and beats,
// raises the frame buffer request and runs start-of-frame recovery

`timescale 1ns/1ps

`include "uvc_reader_config.svh"

module line_fetch_sequencer (
    input  logic                    axi_clk,
    input  logic                    rst_n,
    input  axi_read_pkg::axi_addr_t frame_base_i,
    input  logic                    arready_i,
    input  logic                    rvalid_i,
    input  axi_read_pkg::axi_data_t rdata_i,
    input  logic                    sof_error_i,
    output axi_read_pkg::axi_addr_t araddr_o,
    output logic                    arvalid_o,
    output logic                    frame_request_o,
    output logic                    stream_enable_o,
    beat_push_if.sequencer          push
);

    localparam int LINE_W  = $clog2(`UVC_FRAME_LINES + 1);
    localparam int BEAT_W  = $clog2(`UVC_BEATS_PER_LINE + 1);
    localparam int PAUSE_W = $clog2(`UVC_ERROR_PAUSE);

    axi_read_pkg::fetch_state_e state_q, state_d;

    logic [LINE_W-1:0]  line_cnt_q;
    logic [BEAT_W-1:0]  beat_cnt_q;
    logic [PAUSE_W-1:0] pause_cnt_q;

    logic burst_done, frame_done, room, pause_done, first_beat;

    //------------------------------------------------------------------
    // status decodes
    //------------------------------------------------------------------

    assign burst_done = (beat_cnt_q == BEAT_W'(`UVC_BEATS_PER_LINE));
    assign frame_done = (line_cnt_q == LINE_W'(`UVC_FRAME_LINES));
    assign pause_done = (pause_cnt_q == PAUSE_W'(`UVC_ERROR_PAUSE - 1));
    // a whole line must fit before the next address goes out
    assign room = (push.level <=
        video_stream_pkg::fifo_level_t'(`UVC_FIFO_DEPTH - `UVC_BEATS_PER_LINE));

    // line count already advanced past line 0 during its burst
    assign first_beat = (state_q == axi_read_pkg::LINE_BURST) &&
                        (line_cnt_q == LINE_W'(1)) && (beat_cnt_q == '0);

    assign araddr_o        = frame_base_i +
                             (axi_read_pkg::axi_addr_t'(line_cnt_q) << `UVC_LINE_STRIDE_BITS);
    assign arvalid_o       = (state_q == axi_read_pkg::LINE_ADDR);
    assign stream_enable_o = (state_q != axi_read_pkg::IDLE) &&
                             (state_q != axi_read_pkg::RESYNC);

    assign push.push  = rvalid_i;   // rready is tied high
    assign push.beat  = '{sof: first_beat, data: rdata_i};
    assign push.flush = (state_q == axi_read_pkg::RESYNC) &&
                        (pause_cnt_q >= PAUSE_W'(`UVC_FLUSH_FIRST)) &&
                        (pause_cnt_q <= PAUSE_W'(`UVC_FLUSH_LAST));

    //------------------------------------------------------------------
    // next state
    //------------------------------------------------------------------

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            axi_read_pkg::IDLE:         state_d = axi_read_pkg::LINE_ADDR;
            axi_read_pkg::LINE_ADDR:
            begin
                if (arready_i)
                    state_d = axi_read_pkg::LINE_BURST;
            end
            axi_read_pkg::LINE_BURST:
            begin
                if (burst_done)
                    state_d = axi_read_pkg::WAIT_ROOM;
            end
            axi_read_pkg::WAIT_ROOM:
            begin
                if (frame_done)
                    state_d = axi_read_pkg::FRAME_REQ;
                else if (room)
                    state_d = axi_read_pkg::LINE_ADDR;
            end
            axi_read_pkg::FRAME_REQ:
            begin
                if (room)
                    state_d = axi_read_pkg::FRAME_UPDATE;
            end
            axi_read_pkg::FRAME_UPDATE: state_d = axi_read_pkg::LINE_ADDR;
            axi_read_pkg::RESYNC:
            begin
                if (pause_done)
                    state_d = axi_read_pkg::IDLE;
            end
            default:                    state_d = axi_read_pkg::IDLE;
        endcase

        // mismatch seen by the serializer restarts the frame
        if (sof_error_i && state_q != axi_read_pkg::FRAME_UPDATE)
            state_d = axi_read_pkg::RESYNC;
    end

    //------------------------------------------------------------------
    // state and counters
    //------------------------------------------------------------------

    always_ff @(posedge axi_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state_q         <= axi_read_pkg::IDLE;
            line_cnt_q      <= '0;
            beat_cnt_q      <= '0;
            pause_cnt_q     <= '0;
            frame_request_o <= 1'b0;
        end
        else
        begin
            state_q         <= state_d;
            frame_request_o <= frame_done;

            if (state_q == axi_read_pkg::IDLE || state_q == axi_read_pkg::FRAME_UPDATE ||
                state_q == axi_read_pkg::RESYNC)
                line_cnt_q <= '0;
            else if (arvalid_o && arready_i)
                line_cnt_q <= line_cnt_q + 1'b1;    // counted at the handshake

            if (state_q == axi_read_pkg::LINE_BURST)
                beat_cnt_q <= rvalid_i ? beat_cnt_q + 1'b1 : beat_cnt_q;
            else
                beat_cnt_q <= '0;

            pause_cnt_q <= (state_q == axi_read_pkg::RESYNC) ? pause_cnt_q + 1'b1 : '0;
        end
    end

endmodule

//--- source/beat_fifo.sv
// beat FIFO
// single clock circular buffer of tagged beats with fill level and flush

`timescale 1ns/1ps

`include "uvc_reader_config.svh"

module beat_fifo (
    input  logic     axi_clk,
    input  logic     rst_n,
    beat_push_if.fifo push,
    beat_pop_if.fifo  pop
);

    localparam int PTR_W = $clog2(`UVC_FIFO_DEPTH);

    video_stream_pkg::tagged_beat_t mem [`UVC_FIFO_DEPTH];

    logic [PTR_W-1:0]              wr_ptr_q, rd_ptr_q;
    video_stream_pkg::fifo_level_t count_q;
    logic                          wr_en, rd_en;

    assign wr_en = push.push && (count_q != video_stream_pkg::fifo_level_t'(`UVC_FIFO_DEPTH));
    assign rd_en = pop.pop && (count_q != '0);

    assign push.level    = count_q;
    assign pop.not_empty = (count_q != '0);
    assign pop.head_data = mem[rd_ptr_q].data;
    assign pop.head_sof  = mem[rd_ptr_q].sof;

    // storage
    always_ff @(posedge axi_clk)
    begin
        if (wr_en)
            mem[wr_ptr_q] <= push.beat;
    end

    // pointers wrap at the power of two depth
    always_ff @(posedge axi_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end
        else if (push.flush)
        begin
            wr_ptr_q <= '0;     // drops everything held
            rd_ptr_q <= '0;
            count_q  <= '0;
        end
        else
        begin
            if (wr_en)
                wr_ptr_q <= wr_ptr_q + 1'b1;
            if (rd_en)
                rd_ptr_q <= rd_ptr_q + 1'b1;
            case ({wr_en, rd_en})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;    // none or both
            endcase
        end
    end

endmodule

//--- source/byte_serializer.sv
// byte serializer
// unpacks FIFO beats into bytes, least significant first, and flags
// a consumer frame start that lands on a byte that is not one

`timescale 1ns/1ps

module byte_serializer (
    input  logic                        axi_clk,
    input  logic                        rst_n,
    input  logic                        stream_enable_i,
    input  logic                        uvc_ready_i,
    input  logic                        vf_sof_i,
    output video_stream_pkg::vid_byte_t vf_byte_o,
    output logic                        vf_valid_o,
    output logic                        sof_error_o,
    beat_pop_if.serializer              pop
);

    localparam int BEAT_BYTES = $bits(axi_read_pkg::axi_data_t) / 8;
    localparam int IDX_W      = $clog2(BEAT_BYTES);

    axi_read_pkg::axi_data_t beat_q;
    logic                    loaded_q;
    logic                    sof_q;     // tag of the loaded beat
    logic [IDX_W-1:0]        idx_q;

    logic take, last_byte, load, byte_is_sof;

    assign vf_valid_o  = loaded_q && stream_enable_i;
    assign take        = vf_valid_o && uvc_ready_i;
    assign last_byte   = (idx_q == IDX_W'(BEAT_BYTES - 1));
    assign byte_is_sof = sof_q && (idx_q == '0);   // only byte 0 starts a frame

    // fetch the next beat when empty or as the last byte leaves
    assign load    = stream_enable_i && pop.not_empty && (!loaded_q || (take && last_byte));
    assign pop.pop = load;

    assign vf_byte_o   = beat_q[idx_q*8 +: 8];
    assign sof_error_o = vf_sof_i && vf_valid_o && !byte_is_sof;

    //------------------------------------------------------------------
    // byte stepping
    //------------------------------------------------------------------

    always_ff @(posedge axi_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            loaded_q <= 1'b0;
            sof_q    <= 1'b0;
            idx_q    <= '0;
        end
        else if (!stream_enable_i)
        begin
            loaded_q <= 1'b0;   // stale beat is dropped on resync
            idx_q    <= '0;
        end
        else if (load)
        begin
            loaded_q <= 1'b1;
            sof_q    <= pop.head_sof;
            idx_q    <= '0;
        end
        else if (take)
        begin
            if (last_byte)
                loaded_q <= 1'b0;
            idx_q <= idx_q + 1'b1;  // wraps to byte 0
        end
    end

    always_ff @(posedge axi_clk)
    begin
        if (load)
            beat_q <= pop.head_data;
    end

endmodule

//--- source/uvc_frame_reader.sv
// UVC frame reader top level
// reads a frame buffer line by line over AXI and streams it as bytes
// to the UVC consumer, refetching the frame on a start-of-frame mismatch

`timescale 1ns/1ps

`include "uvc_reader_config.svh"

module uvc_frame_reader (
    input  logic                        axi_clk,
    input  logic                        rst_n,
    // frame buffer handoff
    input  axi_read_pkg::axi_addr_t     frame_buffer_addr_i,
    output logic                        next_frame_buffer_request_o,
    // AXI read address channel
    output axi_read_pkg::axi_addr_t     araddr_o,
    output axi_read_pkg::axi_len_t      arlen_o,
    output axi_read_pkg::axi_size_e     arsize_o,
    output axi_read_pkg::axi_burst_e    arburst_o,
    output logic                        arvalid_o,
    input  logic                        arready_i,
    // AXI read data channel
    input  axi_read_pkg::axi_data_t     rdata_i,
    input  logic                        rvalid_i,
    output logic                        rready_o,
    // byte consumer
    input  logic                        vf_sof_i,
    input  logic                        uvc_ready_i,
    output logic                        vf_valid_o,
    output video_stream_pkg::vid_byte_t vf_byte_o
);

    logic stream_enable;
    logic sof_error;

    beat_push_if push_bus ();
    beat_pop_if  pop_bus ();

    // fixed burst shape, one line per burst
    assign arlen_o   = axi_read_pkg::axi_len_t'(`UVC_BEATS_PER_LINE - 1);
    assign arsize_o  = axi_read_pkg::SIZE_8B;
    assign arburst_o = axi_read_pkg::INCR;
    assign rready_o  = 1'b1;

    line_fetch_sequencer u_sequencer (
        .axi_clk         (axi_clk),
        .rst_n           (rst_n),
        .frame_base_i    (frame_buffer_addr_i),
        .arready_i       (arready_i),
        .rvalid_i        (rvalid_i),
        .rdata_i         (rdata_i),
        .sof_error_i     (sof_error),
        .araddr_o        (araddr_o),
        .arvalid_o       (arvalid_o),
        .frame_request_o (next_frame_buffer_request_o),
        .stream_enable_o (stream_enable),
        .push            (push_bus.sequencer)
    );

    beat_fifo u_fifo (
        .axi_clk (axi_clk),
        .rst_n   (rst_n),
        .push    (push_bus.fifo),
        .pop     (pop_bus.fifo)
    );

    byte_serializer u_serializer (
        .axi_clk         (axi_clk),
        .rst_n           (rst_n),
        .stream_enable_i (stream_enable),
        .uvc_ready_i     (uvc_ready_i),
        .vf_sof_i        (vf_sof_i),
        .vf_byte_o       (vf_byte_o),
        .vf_valid_o      (vf_valid_o),
        .sof_error_o     (sof_error),
        .pop             (pop_bus.serializer)
    );

endmodule

//--- tests/uvc_reader_checker.sv
// UVC frame reader protocol checker
// bound into the top level, watches the AXI address channel and the stream

`timescale 1ns/1ps

`include "uvc_reader_config.svh"

module uvc_reader_checker (
    input logic                    axi_clk,
    input logic                    rst_n,
    input axi_read_pkg::axi_addr_t araddr_o,
    input axi_read_pkg::axi_len_t  arlen_o,
    input logic                    arvalid_o,
    input logic                    arready_i,
    input logic                    vf_valid_o
);

    // address must hold until the slave accepts it
    addr_held: assert property (@(posedge axi_clk) disable iff (!rst_n)
        arvalid_o && !arready_i |=> $stable(araddr_o))
        else $error("araddr_o changed while arvalid_o waited for arready_i");

    quiet_after_reset: assert property (@(posedge axi_clk)
        $rose(rst_n) |-> !arvalid_o && !vf_valid_o)
        else $error("arvalid_o or vf_valid_o high in the first cycle after reset");

    // one line per burst
    burst_length: assert property (@(posedge axi_clk) disable iff (!rst_n)
        arvalid_o |-> arlen_o == axi_read_pkg::axi_len_t'(`UVC_BEATS_PER_LINE - 1))
        else $error("arlen_o does not match one line of beats");

endmodule

bind uvc_frame_reader uvc_reader_checker u_checker (
    .axi_clk    (axi_clk),
    .rst_n      (rst_n),
    .araddr_o   (araddr_o),
    .arlen_o    (arlen_o),
    .arvalid_o  (arvalid_o),
    .arready_i  (arready_i),
    .vf_valid_o (vf_valid_o)
);

//--- tests/tb_uvc_frame_reader.sv
// UVC frame reader testbench
// AXI memory responder, byte consumer with frame start pulses and
// golden file checks of addresses, bytes, frame sums and recovery

`timescale 1ns/1ps

`include "uvc_reader_config.svh"

module tb_uvc_frame_reader;

    localparam int FRAMES         = 4;
    localparam int LINE_BYTES     = `UVC_BEATS_PER_LINE * 8;
    localparam int FRAME_BYTES    = `UVC_FRAME_LINES * LINE_BYTES;
    localparam int FALSE_SOF_BYTE = 3;      // mid-frame byte for the bad pulse
    localparam int STALL_FACTOR   = 16;
    localparam int TIMEOUT_CYCLES = FRAMES * `UVC_FRAME_LINES * `UVC_BEATS_PER_LINE * 8
                                    * STALL_FACTOR;

    logic                        axi_clk;
    logic                        rst_n;
    axi_read_pkg::axi_addr_t     frame_buffer_addr_i;
    logic                        next_frame_buffer_request_o;
    axi_read_pkg::axi_addr_t     araddr_o;
    axi_read_pkg::axi_len_t      arlen_o;
    axi_read_pkg::axi_size_e     arsize_o;
    axi_read_pkg::axi_burst_e    arburst_o;
    logic                        arvalid_o;
    logic                        arready_i;
    axi_read_pkg::axi_data_t     rdata_i;
    logic                        rvalid_i;
    logic                        rready_o;
    logic                        vf_sof_i;
    logic                        uvc_ready_i;
    logic                        vf_valid_o;
    video_stream_pkg::vid_byte_t vf_byte_o;

    logic [31:0] golden_mem [0:FRAMES*4-1];
    logic [31:0] lfsr_q;
    int          cycle_cnt;

    // fetch side model
    int                      fetch_line;
    int                      drv_frame;
    int                      burst_left;
    int                      req_due;
    logic                    req_prev;
    axi_read_pkg::axi_addr_t beat_addr;
    video_stream_pkg::vid_byte_t burst_key;

    // consumer side model
    int                cons_frame;
    int                cons_idx;
    logic [15:0]       frame_sum;
    logic              wait_restart;
    logic              false_pending;
    logic              valid_check_due;
    logic [FRAMES-1:0] injected;

    uvc_frame_reader dut (
        .axi_clk                     (axi_clk),
        .rst_n                       (rst_n),
        .frame_buffer_addr_i         (frame_buffer_addr_i),
        .next_frame_buffer_request_o (next_frame_buffer_request_o),
        .araddr_o                    (araddr_o),
        .arlen_o                     (arlen_o),
        .arsize_o                    (arsize_o),
        .arburst_o                   (arburst_o),
        .arvalid_o                   (arvalid_o),
        .arready_i                   (arready_i),
        .rdata_i                     (rdata_i),
        .rvalid_i                    (rvalid_i),
        .rready_o                    (rready_o),
        .vf_sof_i                    (vf_sof_i),
        .uvc_ready_i                 (uvc_ready_i),
        .vf_valid_o                  (vf_valid_o),
        .vf_byte_o                   (vf_byte_o)
    );

    //----------------------------------------------------------------------
    // golden file fields and expected data
    //----------------------------------------------------------------------

    function automatic axi_read_pkg::axi_addr_t golden_base(input int f);
        return golden_mem[4*f];
    endfunction

    function automatic video_stream_pkg::vid_byte_t golden_key(input int f);
        return golden_mem[4*f+1][7:0];
    endfunction

    function automatic logic golden_flag(input int f);
        return golden_mem[4*f+2][0];
    endfunction

    // byte k at address A is the low byte of A+k xor the key
    function automatic video_stream_pkg::vid_byte_t expected_byte(input int f, input int idx);
        axi_read_pkg::axi_addr_t a;
        a = golden_base(f) + axi_read_pkg::axi_addr_t'((idx / LINE_BYTES) * 2048
                                                       + idx % LINE_BYTES);
        return a[7:0] ^ golden_key(f);
    endfunction

    function automatic axi_read_pkg::axi_data_t make_beat(input axi_read_pkg::axi_addr_t a,
                                                          input video_stream_pkg::vid_byte_t key);
        axi_read_pkg::axi_data_t beat;
        axi_read_pkg::axi_addr_t ak;
        for (int k = 0; k < 8; k++)
        begin
            ak = a + axi_read_pkg::axi_addr_t'(k);
            beat[k*8 +: 8] = ak[7:0] ^ key;
        end
        return beat;
    endfunction

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic draw_bit(output logic b);
        lfsr_q = lfsr_next(lfsr_q);
        b      = lfsr_q[0];
    endtask

    //----------------------------------------------------------------------
    // checks
    //----------------------------------------------------------------------

    task automatic abort_run();
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_problem(input string msg);
        $display("%s", msg);
        abort_run();
    endtask

    task automatic compare_addr(input string name, input axi_read_pkg::axi_addr_t got,
                                input axi_read_pkg::axi_addr_t exp);
        if (got !== exp)
        begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic compare_byte(input string name, input video_stream_pkg::vid_byte_t got,
                                input video_stream_pkg::vid_byte_t exp);
        if (got !== exp)
        begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic compare_sum(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp)
        begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    //----------------------------------------------------------------------
    // per cycle models
    //----------------------------------------------------------------------

    task automatic check_request();
        if (req_due > 0)
        begin
            req_due = req_due - 1;
            if (req_due == 0)
                compare_bit("next_frame_buffer_request_o", next_frame_buffer_request_o, 1'b1);
        end
    endtask

    task automatic accept_beat();
        compare_bit("rready_o", rready_o, 1'b1);   // read data is never stalled
        if (rvalid_i && burst_left > 0)
        begin
            burst_left = burst_left - 1;
            beat_addr  = beat_addr + 32'd8;
        end
    endtask

    task automatic watch_address();
        if (arvalid_o && arready_i)
        begin
            if (wait_restart)
            begin
                cons_frame   = drv_frame;   // refetch takes whatever base is current
                wait_restart = 1'b0;
            end
            compare_addr("araddr_o", araddr_o, golden_base(drv_frame)
                         + axi_read_pkg::axi_addr_t'(fetch_line * 2048));
            compare_bit("arburst_o is INCR", arburst_o == axi_read_pkg::INCR, 1'b1);
            compare_bit("arsize_o is 8 bytes", arsize_o == axi_read_pkg::SIZE_8B, 1'b1);
            burst_left = `UVC_BEATS_PER_LINE;
            beat_addr  = araddr_o;
            burst_key  = golden_key(drv_frame);
            if (fetch_line == `UVC_FRAME_LINES - 1)
            begin
                fetch_line = 0;
                req_due    = 2;     // registered request, seen two edges later
            end
            else
                fetch_line = fetch_line + 1;
        end
    endtask

    task automatic consume_byte();
        logic                        took;
        logic                        b;
        video_stream_pkg::vid_byte_t exp_byte;
        took = uvc_ready_i && vf_valid_o;
        if (valid_check_due)
        begin
            valid_check_due = 1'b0;
            compare_bit("vf_valid_o", vf_valid_o, 1'b0);
        end
        if (took && wait_restart)
            report_problem("a byte was delivered before the frame was fetched again");
        if (took && cons_frame < FRAMES)
        begin
            exp_byte = expected_byte(cons_frame, cons_idx);
            compare_byte("vf_byte_o", vf_byte_o, exp_byte);
            frame_sum = frame_sum + {8'h00, vf_byte_o};
            if (false_pending)
            begin
                // bad pulse landed, the reader must restart the frame
                false_pending   = 1'b0;
                wait_restart    = 1'b1;
                valid_check_due = 1'b1;
                fetch_line      = 0;
                burst_left      = 0;
                cons_idx        = 0;
                frame_sum       = '0;
            end
            else
            begin
                cons_idx = cons_idx + 1;
                if (cons_idx == FRAME_BYTES)
                begin
                    compare_sum("frame byte sum", frame_sum, golden_mem[4*cons_frame+3][15:0]);
                    cons_frame = cons_frame + 1;
                    cons_idx   = 0;
                    frame_sum  = '0;
                end
            end
        end

        // start pulses are held with ready until the byte is taken
        if (cons_frame >= FRAMES)
        begin
            uvc_ready_i <= 1'b0;
            vf_sof_i    <= 1'b0;
        end
        else if (cons_idx == 0 || false_pending ||
                 (golden_flag(cons_frame) && !injected[cons_frame] &&
                  cons_idx == FALSE_SOF_BYTE))
        begin
            if (cons_idx == FALSE_SOF_BYTE && !false_pending)
            begin
                false_pending        = 1'b1;
                injected[cons_frame] = 1'b1;
            end
            uvc_ready_i <= 1'b1;
            vf_sof_i    <= 1'b1;
        end
        else
        begin
            draw_bit(b);
            uvc_ready_i <= b;
            vf_sof_i    <= 1'b0;
        end
    endtask

    task automatic drive_read_data();
        logic b0, b1;
        if (burst_left > 0)
        begin
            draw_bit(b0);
            draw_bit(b1);
            rvalid_i <= b0 | b1;    // stalls a quarter of the time
            rdata_i  <= make_beat(beat_addr, burst_key);
        end
        else
        begin
            rvalid_i <= 1'b0;
            rdata_i  <= '0;
        end
    endtask

    task automatic follow_request();
        if (next_frame_buffer_request_o && !req_prev && drv_frame < FRAMES - 1)
        begin
            drv_frame           = drv_frame + 1;
            frame_buffer_addr_i <= golden_base(drv_frame);
        end
        req_prev = next_frame_buffer_request_o;
    endtask

    //----------------------------------------------------------------------
    // clock, reset and run control
    //----------------------------------------------------------------------

    initial
    begin
        axi_clk = 1'b0;
        forever #5 axi_clk = ~axi_clk;
    end

    initial
    begin
        rst_n           = 1'b0;
        arready_i       = 1'b0;
        rvalid_i        = 1'b0;
        rdata_i         = '0;
        vf_sof_i        = 1'b0;
        uvc_ready_i     = 1'b0;
        lfsr_q          = 32'h64d8;
        cycle_cnt       = 0;
        fetch_line      = 0;
        drv_frame       = 0;
        burst_left      = 0;
        req_due         = 0;
        req_prev        = 1'b0;
        beat_addr       = '0;
        burst_key       = '0;
        cons_frame      = 0;
        cons_idx        = 0;
        frame_sum       = '0;
        wait_restart    = 1'b0;
        false_pending   = 1'b0;
        valid_check_due = 1'b0;
        injected        = '0;
        $readmemh("tests/uvc_reader_golden.txt", golden_mem);
        frame_buffer_addr_i = golden_mem[0];
        if ($isunknown(golden_mem[FRAMES*4-1]))
            report_problem("the golden file could not be read completely");
        repeat (8) @(posedge axi_clk);
        rst_n <= 1'b1;
        wait (cons_frame == FRAMES);
        @(posedge axi_clk);
        $display("Simulation finished: PASS");
        $finish;
    end

    always @(posedge axi_clk)
    begin
        logic b;
        if (rst_n)
        begin
            check_request();
            accept_beat();
            watch_address();
            consume_byte();
            drive_read_data();
            follow_request();
            draw_bit(b);
            arready_i <= b;
        end
    end

    always @(posedge axi_clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES)
            report_problem("timeout, the frames were not delivered within the cycle limit");
    end

endmodule

//--- all.f
+incdir+include
source/axi_read_pkg.sv
source/video_stream_pkg.sv
source/fetch_ifs.sv
source/line_fetch_sequencer.sv
source/beat_fifo.sv
source/byte_serializer.sv
source/uvc_frame_reader.sv
tests/uvc_reader_checker.sv
tests/tb_uvc_frame_reader.sv

//--- run_sim.sh
#!/bin/sh
# builds the UVC frame reader testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f all.f \
    --top-module tb_uvc_frame_reader \
    -o sim_tb > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status, see build.log"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status, see sim.log"
fi

if grep -q "Simulation finished: PASS" sim.log; then
    if [ $status -ne 0 ]; then
        exit 1
    fi
    echo "test passed"
    exit 0
else
    echo "test failed, see sim.log"
    exit 1
fi

//--- tests/uvc_reader_golden.txt
// columns: frame base address, key byte, false start-of-frame flag, expected byte sum
// one frame per line, all values in hex
00100000 5a 0 27c0
00200040 c3 1 47c0
00300000 17 0 07c0
00410080 a5 1 17c0
